// File: Makefile
TOP := scoreboard_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

obj_dir/V$(TOP): filelist.f design/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

// File: design/completion_stage.sv
// Completion stage
// One fixed-latency shift pipeline per execution unit
// Completion toggles of the in-use memory and the registered retire report
`default_nettype none

module completion_stage #(
    parameter int NUM_UNITS = sb_config_pkg::NUM_UNITS
) (
    input  logic                    clk,
    input  logic                    arst_n,
    issue_if.executor               exe,
    output logic [NUM_UNITS-1:0]    unit_toggle,
    output sb_types_pkg::reg_addr_t unit_toggle_addr [NUM_UNITS],
    output logic [NUM_UNITS-1:0]    retire_valid,
    output sb_types_pkg::reg_addr_t retire_rd [NUM_UNITS]
);
    import sb_config_pkg::*;
    import sb_types_pkg::*;

    for (genvar u = 0; u < NUM_UNITS; u++) begin : unit_gen
        localparam int LAT = UNIT_LATENCY[u];

        // Stage 0 loads at the issue edge, last stage completes
        logic      stage_valid [LAT];
        reg_addr_t stage_rd    [LAT];
        logic      stage_wr    [LAT];
        logic      ret_valid;
        reg_addr_t ret_rd;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                for (int s = 0; s < LAT; s++) begin
                    stage_valid[s] <= 1'b0;
                end
                ret_valid <= 1'b0;
            end else begin
                stage_valid[0] <= exe.valid && (exe.unit == unit_id_t'(u));
                for (int s = 1; s < LAT; s++) begin
                    stage_valid[s] <= stage_valid[s-1];
                end
                ret_valid <= stage_valid[LAT-1];
            end
        end

        // Payload follows the valid bits
        always_ff @(posedge clk) begin
            stage_rd[0] <= exe.rd;
            stage_wr[0] <= exe.writes_rd;
            for (int s = 1; s < LAT; s++) begin
                stage_rd[s] <= stage_rd[s-1];
                stage_wr[s] <= stage_wr[s-1];
            end
            ret_rd <= stage_rd[LAT-1];
        end

        // Clear the mark at the completion edge, retire shows one cycle later
        assign unit_toggle[u]      = stage_valid[LAT-1] && stage_wr[LAT-1];
        assign unit_toggle_addr[u] = stage_rd[LAT-1];
        assign retire_valid[u]     = ret_valid;
        assign retire_rd[u]        = ret_rd;
    end

endmodule

`default_nettype wire

// File: design/issue_if.sv
// Issue bundle from the issue stage to the execution units
// No handshake, the units accept every cycle
`default_nettype none

interface issue_if;
    import sb_types_pkg::*;

    // Instruction issued this cycle
    logic      valid;
    // Destination register
    reg_addr_t rd;
    // Target execution unit
    unit_id_t  unit;
    // Destination is not x0, so completion must clear its in-use mark
    logic      writes_rd;

    // Issue stage side
    modport issuer (output valid, output rd, output unit, output writes_rd);

    // Execution unit side
    modport executor (input valid, input rd, input unit, input writes_rd);

endinterface

`default_nettype wire

// File: design/issue_stage.sv
// Issue stage
// Credit-managed circular instruction queue
// Hazard check of the queue head and in-order issue
`default_nettype none

module issue_stage #(
    parameter int QUEUE_DEPTH = sb_config_pkg::ISSUE_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  sb_types_pkg::reg_addr_t in_rd,
    input  sb_types_pkg::reg_addr_t in_rs1,
    input  sb_types_pkg::reg_addr_t in_rs2,
    input  sb_types_pkg::unit_id_t  in_unit,
    output logic                    in_credit,
    input  logic                    ready,
    output sb_types_pkg::reg_addr_t head_addr [3],
    input  logic [2:0]              in_use,
    output logic                    issue_toggle,
    output sb_types_pkg::reg_addr_t issue_toggle_addr,
    issue_if.issuer                 iss
);
    import sb_types_pkg::*;

    // Queue payload
    reg_addr_t q_rd  [QUEUE_DEPTH];
    reg_addr_t q_rs1 [QUEUE_DEPTH];
    reg_addr_t q_rs2 [QUEUE_DEPTH];
    unit_id_t  q_unit [QUEUE_DEPTH];

    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;
    queue_cnt_t occupancy;
    reg_addr_t  head_rd;
    logic       issue;

    // Pointer advance with wrap at QUEUE_DEPTH
    function automatic queue_ptr_t next_ptr(input queue_ptr_t ptr);
        if (ptr == queue_ptr_t'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////
    // Queue storage

    // Upstream only sends while it holds a credit, so no full check here
    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_rd[wr_ptr]   <= in_rd;
            q_rs1[wr_ptr]  <= in_rs1;
            q_rs2[wr_ptr]  <= in_rs2;
            q_unit[wr_ptr] <= in_unit;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            occupancy <= occupancy + queue_cnt_t'(in_valid) - queue_cnt_t'(issue);
        end
    end

    //////////////////////////////
    // Hazard check and issue

    assign head_rd = q_rd[rd_ptr];

    // Lookup order is rs1, rs2, rd
    assign head_addr[0] = q_rs1[rd_ptr];
    assign head_addr[1] = q_rs2[rd_ptr];
    assign head_addr[2] = head_rd;

    // Oldest entry goes when clearing is done and no operand is in use
    assign issue = ready && (occupancy != '0) && (in_use == 3'b000);

    // x0 is never marked in use
    assign issue_toggle      = issue && (head_rd != '0);
    assign issue_toggle_addr = head_rd;

    // One credit back per issued entry
    assign in_credit = issue;

    assign iss.valid     = issue;
    assign iss.rd        = head_rd;
    assign iss.unit      = q_unit[rd_ptr];
    assign iss.writes_rd = (head_rd != '0);

endmodule

`default_nettype wire

// File: design/lfsr.sv
// Fibonacci LFSR with zero insertion
// Visits all 2^WIDTH values once per period, starting from zero
`default_nettype none

module lfsr #(
    parameter int WIDTH = 5
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             en,
    output logic [WIDTH-1:0] value
);
    // Maximal-length tap masks for widths 2 to 8
    localparam logic [7:0] TAP_TABLE [2:8] = '{8'h03, 8'h06, 8'h0C, 8'h14, 8'h30, 8'h60, 8'hB8};
    localparam logic [WIDTH-1:0] TAPS = TAP_TABLE[WIDTH][WIDTH-1:0];

    logic feedback;

    // XOR of taps, inverted when all bits below the MSB are zero
    // This splices the all-zero state in between 10..0 and 0..01
    assign feedback = (^(value & TAPS)) ^ (value[WIDTH-2:0] == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value <= '0;
        end else if (en) begin
            value <= {value[WIDTH-2:0], feedback};
        end
    end

endmodule

`default_nettype wire

// File: design/sb_config_pkg.sv
// Scoreboard configuration constants
// Register count, execution unit count, issue queue depth, unit latencies
`default_nettype none

package sb_config_pkg;

    // Architectural registers tracked by the scoreboard
    localparam int REG_COUNT = 32;

    // Fixed-latency execution units
    localparam int NUM_UNITS = 2;

    // Issue queue entries
    // Also the number of credits granted upstream after reset
    localparam int ISSUE_DEPTH = 4;

    // Cycles from issue to completion, indexed by unit number
    // Unit 0 is the short pipe, unit 1 the long one
    localparam int UNIT_LATENCY [NUM_UNITS] = '{1, 3};

endpackage

`default_nettype wire

// File: design/sb_types_pkg.sv
// Scoreboard types
// Register, unit, queue pointer and queue count widths
// Post-reset clearing state encoding
`default_nettype none

package sb_types_pkg;

    // Architectural register index
    typedef logic [$clog2(sb_config_pkg::REG_COUNT)-1:0] reg_addr_t;

    // Execution unit number
    typedef logic [$clog2(sb_config_pkg::NUM_UNITS)-1:0] unit_id_t;

    // Issue queue read and write pointers
    typedef logic [$clog2(sb_config_pkg::ISSUE_DEPTH)-1:0] queue_ptr_t;

    // Queue occupancy, one extra bit so that a full queue fits
    typedef logic [$clog2(sb_config_pkg::ISSUE_DEPTH+1)-1:0] queue_cnt_t;

    // In-use memory clearing FSM
    typedef enum logic {
        CLEAR_RUN,
        CLEAR_DONE
    } clear_state_t;

endpackage

`default_nettype wire

// File: design/scoreboard_top.sv
// Scoreboard top level
// Issue stage, completion stage and the in-use memory bank
`default_nettype none

module scoreboard_top #(
    parameter int DEPTH       = sb_config_pkg::REG_COUNT,
    parameter int NUM_UNITS   = sb_config_pkg::NUM_UNITS,
    parameter int QUEUE_DEPTH = sb_config_pkg::ISSUE_DEPTH
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  sb_types_pkg::reg_addr_t in_rd,
    input  sb_types_pkg::reg_addr_t in_rs1,
    input  sb_types_pkg::reg_addr_t in_rs2,
    input  sb_types_pkg::unit_id_t  in_unit,
    output logic                    in_credit,
    output logic [NUM_UNITS-1:0]    retire_valid,
    output sb_types_pkg::reg_addr_t retire_rd [NUM_UNITS],
    output logic                    init_done
);
    import sb_types_pkg::*;

    // Write port 0 is issue, ports 1 and up are the units
    localparam int NUM_WRITE = NUM_UNITS + 1;

    logic                 ready;
    reg_addr_t            head_addr [3];
    logic [2:0]           in_use;
    logic                 issue_toggle;
    reg_addr_t            issue_toggle_addr;
    logic [NUM_UNITS-1:0] unit_toggle;
    reg_addr_t            unit_toggle_addr [NUM_UNITS];
    logic [NUM_WRITE-1:0] all_toggle;
    reg_addr_t            all_toggle_addr [NUM_WRITE];

    issue_if iss_bus ();

    assign all_toggle = {unit_toggle, issue_toggle};

    always_comb begin
        all_toggle_addr[0] = issue_toggle_addr;
        for (int u = 0; u < NUM_UNITS; u++) begin
            all_toggle_addr[u+1] = unit_toggle_addr[u];
        end
    end

    assign init_done = ready;

    issue_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) issue0 (
        .clk               (clk),
        .arst_n            (arst_n),
        .in_valid          (in_valid),
        .in_rd             (in_rd),
        .in_rs1            (in_rs1),
        .in_rs2            (in_rs2),
        .in_unit           (in_unit),
        .in_credit         (in_credit),
        .ready             (ready),
        .head_addr         (head_addr),
        .in_use            (in_use),
        .issue_toggle      (issue_toggle),
        .issue_toggle_addr (issue_toggle_addr),
        .iss               (iss_bus.issuer)
    );

    completion_stage #(
        .NUM_UNITS (NUM_UNITS)
    ) completion0 (
        .clk              (clk),
        .arst_n           (arst_n),
        .exe              (iss_bus.executor),
        .unit_toggle      (unit_toggle),
        .unit_toggle_addr (unit_toggle_addr),
        .retire_valid     (retire_valid),
        .retire_rd        (retire_rd)
    );

    toggle_memory_set #(
        .DEPTH     (DEPTH),
        .NUM_WRITE (NUM_WRITE)
    ) in_use_mem (
        .clk         (clk),
        .arst_n      (arst_n),
        .toggle      (all_toggle),
        .toggle_addr (all_toggle_addr),
        .read_addr   (head_addr),
        .in_use      (in_use),
        .ready       (ready)
    );

endmodule

`default_nettype wire

// File: design/toggle_memory.sv
// Single-bit toggle memory
// One flip write port, NUM_READ combinational read ports
`default_nettype none

module toggle_memory #(
    parameter int DEPTH    = 32,
    parameter int NUM_READ = 4
) (
    input  logic                    clk,
    input  logic                    toggle,
    input  sb_types_pkg::reg_addr_t toggle_addr,
    input  sb_types_pkg::reg_addr_t read_addr [NUM_READ],
    output logic [NUM_READ-1:0]     read_data
);
    // One flip bit per register, cleared by the walk after reset
    logic [DEPTH-1:0] flip_bits;

    // A write inverts the addressed bit
    always_ff @(posedge clk) begin
        if (toggle) begin
            flip_bits[toggle_addr] <= ~flip_bits[toggle_addr];
        end
    end

    // Reads see the current contents, no read latency
    always_comb begin
        for (int r = 0; r < NUM_READ; r++) begin
            read_data[r] = flip_bits[read_addr[r]];
        end
    end

endmodule

`default_nettype wire

// File: design/toggle_memory_set.sv
// Bank of toggle memories, one per write port plus one for clearing
// In-use lookup for three addresses as the XOR over all copies
// Post-reset clearing FSM driven by an LFSR walk
`default_nettype none

module toggle_memory_set #(
    parameter int DEPTH     = 32,
    parameter int NUM_WRITE = 3
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [NUM_WRITE-1:0]    toggle,
    input  sb_types_pkg::reg_addr_t toggle_addr [NUM_WRITE],
    input  sb_types_pkg::reg_addr_t read_addr [3],
    output logic [2:0]              in_use,
    output logic                    ready
);
    import sb_types_pkg::*;

    // Three lookup ports plus the clearing port
    localparam int NUM_READ = 3;

    // Last LFSR value before it wraps back to zero, only the MSB set
    // Requires DEPTH to be a power of two
    localparam reg_addr_t LAST_INDEX = reg_addr_t'(DEPTH / 2);

    clear_state_t state;
    logic         clearing;
    reg_addr_t    clear_index;

    // Port arrays including the extra clearing ports
    logic [NUM_WRITE:0]  mem_toggle;
    reg_addr_t           mem_addr      [NUM_WRITE+1];
    reg_addr_t           mem_read_addr [NUM_READ+1];
    logic [NUM_READ:0]   read_data     [NUM_WRITE+1];
    logic [NUM_READ:0]   read_in_use;

    //////////////////////////////
    // Clearing walk

    assign clearing = (state == CLEAR_RUN);

    // Unordered index, every register visited once in DEPTH steps
    lfsr #(
        .WIDTH ($clog2(DEPTH))
    ) clear_lfsr (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (clearing),
        .value  (clear_index)
    );

    // Run for exactly DEPTH cycles, then stay done until the next reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CLEAR_RUN;
        end else if (clearing && (clear_index == LAST_INDEX)) begin
            state <= CLEAR_DONE;
        end
    end

    assign ready = (state == CLEAR_DONE);

    //////////////////////////////
    // Port muxing

    always_comb begin
        mem_toggle[NUM_WRITE-1:0] = toggle;
        for (int w = 0; w < NUM_WRITE; w++) begin
            mem_addr[w] = toggle_addr[w];
        end
        for (int r = 0; r < NUM_READ; r++) begin
            mem_read_addr[r] = read_addr[r];
        end
        // Clearing flips only entries that currently read in use
        mem_toggle[NUM_WRITE]  = clearing && read_in_use[NUM_READ];
        mem_addr[NUM_WRITE]    = clear_index;
        mem_read_addr[NUM_READ] = clear_index;
    end

    //////////////////////////////
    // Memories and in-use

    for (genvar w = 0; w <= NUM_WRITE; w++) begin : mem_gen
        toggle_memory #(
            .DEPTH    (DEPTH),
            .NUM_READ (NUM_READ + 1)
        ) mem (
            .clk         (clk),
            .toggle      (mem_toggle[w]),
            .toggle_addr (mem_addr[w]),
            .read_addr   (mem_read_addr),
            .read_data   (read_data[w])
        );
    end

    // A register is in use when its copies disagree in parity
    always_comb begin
        read_in_use = '0;
        for (int w = 0; w <= NUM_WRITE; w++) begin
            read_in_use ^= read_data[w];
        end
    end

    assign in_use = read_in_use[NUM_READ-1:0];

endmodule

`default_nettype wire

// File: filelist.f
design/sb_config_pkg.sv
design/sb_types_pkg.sv
design/issue_if.sv
design/lfsr.sv
design/toggle_memory.sv
design/toggle_memory_set.sv
design/issue_stage.sv
design/completion_stage.sv
design/scoreboard_top.sv
testbench/scoreboard_asserts.sv
testbench/scoreboard_tb.sv

// File: testbench/scoreboard_asserts.sv
// Concurrent checks bound into the issue stage
// Credit return, occupancy bound, issue gated by the clearing walk
`default_nettype none

module scoreboard_asserts #(
    parameter int QUEUE_DEPTH  = 4,
    parameter int CLEAR_CYCLES = 32
) (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     in_valid,
    input logic                     in_credit,
    input sb_types_pkg::queue_cnt_t occupancy,
    input logic                     issue_toggle
);
    timeunit 1ns;
    timeprecision 1ps;

    import sb_types_pkg::*;

    // Failed assertions so far, read by the testbench summary
    int failures = 0;

    // Entries accepted and not yet credited, seen from the ports only
    int entries;
    // Cycles since reset release, held at the clearing length
    int clear_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entries   <= 0;
            clear_cnt <= 0;
        end else begin
            entries <= entries + int'(in_valid) - int'(in_credit);
            if (clear_cnt < CLEAR_CYCLES) begin
                clear_cnt <= clear_cnt + 1;
            end
        end
    end

    // A credit only comes back from an entry that leaves the queue
    credit_from_entry: assert property (
        @(posedge clk) disable iff (!arst_n) in_credit |-> (entries > 0)
    ) else begin
        failures++;
        $error("credit returned while the issue queue was empty");
    end

    // Upstream never holds more credits than entries
    occupancy_bound: assert property (
        @(posedge clk) disable iff (!arst_n) occupancy <= queue_cnt_t'(QUEUE_DEPTH)
    ) else begin
        failures++;
        $error("issue queue occupancy above its depth");
    end

    // No marks before the in-use memory is clean
    issue_after_clear: assert property (
        @(posedge clk) disable iff (!arst_n) (clear_cnt < CLEAR_CYCLES) |-> !issue_toggle
    ) else begin
        failures++;
        $error("issue toggle while the clearing walk was running");
    end

endmodule

`default_nettype wire

// File: testbench/scoreboard_stim.txt
// Hex tokens. Header: run count, then per run: instruction count, stale count, retire count
// Instruction: rd rs1 rs2 unit gap. Retire: unit rd, in order, same cycle by unit
02
// Run 1, overtake, RAW, WAW and x0 cases
0a 02 0a
01 00 00 1 0
02 00 00 0 1
03 01 02 0 0
04 03 00 1 0
04 00 00 0 0
00 00 00 1 0
05 00 00 1 2
06 05 00 0 0
00 06 06 0 0
08 00 00 1 0
// Stale, still in flight at the second reset
07 00 00 1 0
09 00 00 1 0
0 02
1 01
0 03
1 04
0 04
1 00
1 05
0 06
0 00
1 08
// Run 2, sources marked before the reset
04 00 04
0a 07 09 1 0
0b 07 00 0 1
0c 0a 0b 0 0
09 0c 00 1 0
0 0b
1 0a
0 0c
1 09

// File: testbench/scoreboard_tb.sv
// Scoreboard testbench
// File-driven instruction stream with credit tracking
// Clearing latency, retire order and credit checks, watchdog and summary
`default_nettype none

module scoreboard_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sb_config_pkg::*;
    import sb_types_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_RUNS   = 4;
    localparam int MAX_ITEMS  = 64;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    reg_addr_t            in_rd;
    reg_addr_t            in_rs1;
    reg_addr_t            in_rs2;
    unit_id_t             in_unit;
    logic                 in_credit;
    logic [NUM_UNITS-1:0] retire_valid;
    reg_addr_t            retire_rd [NUM_UNITS];
    logic                 init_done;

    // Raw hex tokens and the read position
    logic [7:0] stim [0:255];
    int         pos;

    // Parsed stimulus, per run and flat over all runs
    int         num_runs;
    int         run_instr [MAX_RUNS];
    int         run_stale [MAX_RUNS];
    int         run_ret   [MAX_RUNS];
    reg_addr_t  ins_rd    [MAX_ITEMS];
    reg_addr_t  ins_rs1   [MAX_ITEMS];
    reg_addr_t  ins_rs2   [MAX_ITEMS];
    unit_id_t   ins_unit  [MAX_ITEMS];
    int         ins_gap   [MAX_ITEMS];
    unit_id_t   ret_unit  [MAX_ITEMS];
    reg_addr_t  ret_rd    [MAX_ITEMS];
    int         ins_next;
    int         ret_next;
    int         ret_end;

    int seed = 32'h9650;
    int credits;
    int watchdog_cycles;
    int retire_errors;
    int credit_errors;
    int init_errors;
    int other_errors;
    int total_errors;

    scoreboard_top #(
        .DEPTH       (REG_COUNT),
        .NUM_UNITS   (NUM_UNITS),
        .QUEUE_DEPTH (ISSUE_DEPTH)
    ) dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_unit      (in_unit),
        .in_credit    (in_credit),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .init_done    (init_done)
    );

    bind issue_stage scoreboard_asserts #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .CLEAR_CYCLES (sb_config_pkg::REG_COUNT)
    ) asserts0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_credit    (in_credit),
        .occupancy    (occupancy),
        .issue_toggle (issue_toggle)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Stimulus file

    function automatic int next_token();
        next_token = int'(stim[pos]);
        pos++;
    endfunction

    // Header, instruction lines incl. stale ones, then expected retires
    task automatic load_stimulus();
        int n_ins;
        int n_ret;
        int max_lat;
        $readmemh("testbench/scoreboard_stim.txt", stim);
        pos      = 0;
        n_ins    = 0;
        n_ret    = 0;
        max_lat  = 0;
        num_runs = next_token();
        for (int r = 0; r < num_runs; r++) begin
            run_instr[r] = next_token();
            run_stale[r] = next_token();
            run_ret[r]   = next_token();
            for (int i = 0; i < run_instr[r] + run_stale[r]; i++) begin
                ins_rd[n_ins]   = reg_addr_t'(next_token());
                ins_rs1[n_ins]  = reg_addr_t'(next_token());
                ins_rs2[n_ins]  = reg_addr_t'(next_token());
                ins_unit[n_ins] = unit_id_t'(next_token());
                ins_gap[n_ins]  = next_token();
                n_ins++;
            end
            for (int i = 0; i < run_ret[r]; i++) begin
                ret_unit[n_ret] = unit_id_t'(next_token());
                ret_rd[n_ret]   = reg_addr_t'(next_token());
                n_ret++;
            end
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (UNIT_LATENCY[u] > max_lat) begin
                max_lat = UNIT_LATENCY[u];
            end
        end
        // Reset, clearing and drain per run, hazard wait and gaps per instruction
        watchdog_cycles = num_runs * (REG_COUNT + 40) + 50;
        for (int i = 0; i < n_ins; i++) begin
            watchdog_cycles += max_lat + 4 + ins_gap[i];
        end
    endtask

    //////////////////////////////
    // Compare tasks

    task automatic check_retire(input unit_id_t unit, input reg_addr_t rd,
                                input unit_id_t exp_unit, input reg_addr_t exp_rd);
        if (unit !== exp_unit || rd !== exp_rd) begin
            $display("Error %0t: retire unit %0d rd %0d, expected unit %0d rd %0d",
                     $time, unit, rd, exp_unit, exp_rd);
            retire_errors++;
        end
    endtask

    task automatic check_credits(input queue_cnt_t actual, input queue_cnt_t expected);
        if (actual !== expected) begin
            $display("Error %0t: credit count %0d, expected %0d", $time, actual, expected);
            credit_errors++;
        end
    endtask

    task automatic check_init_cycles(input int actual, input int expected);
        if (actual != expected) begin
            $display("Error %0t: init_done after %0d cycles, expected %0d",
                     $time, actual, expected);
            init_errors++;
        end
    endtask

    //////////////////////////////
    // Per-cycle work on the falling edge

    // Credits and retires are stable between rising edges
    task automatic sample_cycle();
        if (in_credit) begin
            credits++;
        end
        if (credits > ISSUE_DEPTH) begin
            $display("More credits came back than instructions were sent, at %0t", $time);
            other_errors++;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (retire_valid[u]) begin
                if (ret_next < ret_end) begin
                    check_retire(unit_id_t'(u), retire_rd[u], ret_unit[ret_next],
                                 ret_rd[ret_next]);
                    ret_next++;
                end else begin
                    $display("Unexpected retire from unit %0d with rd %0d at %0t",
                             u, retire_rd[u], $time);
                    other_errors++;
                end
            end
        end
    endtask

    // Spends one credit
    task automatic drive_instr();
        in_valid = 1'b1;
        in_rd    = ins_rd[ins_next];
        in_rs1   = ins_rs1[ins_next];
        in_rs2   = ins_rs2[ins_next];
        in_unit  = ins_unit[ins_next];
        credits--;
        ins_next++;
    endtask

    //////////////////////////////
    // Test phases

    // Reset for 10 cycles, then upstream holds a full set of credits
    task automatic apply_reset();
        arst_n   = 1'b0;
        in_valid = 1'b0;
        repeat (10) @(negedge clk);
        arst_n  = 1'b1;
        credits = ISSUE_DEPTH;
    endtask

    // Sending starts at reset release, so entries wait in the queue while clearing runs
    task automatic run_sequence(input int run);
        int   last;
        int   gap;
        int   drain;
        int   clear_cycles;
        logic init_seen;
        last         = ins_next + run_instr[run];
        ret_end      = ret_next + run_ret[run];
        gap          = 0;
        clear_cycles = 0;
        init_seen    = 1'b0;
        while (ins_next < last || !init_seen) begin
            @(negedge clk);
            in_valid = 1'b0;
            if (!init_done) begin
                clear_cycles++;
                if (retire_valid != '0 || in_credit) begin
                    $display("Retire or credit seen while the in-use memory was clearing");
                    other_errors++;
                end
            end else begin
                if (!init_seen) begin
                    check_init_cycles(clear_cycles + 1, REG_COUNT);
                    init_seen = 1'b1;
                end
                sample_cycle();
            end
            if (gap > 0) begin
                gap--;
            end else if (credits > 0 && ins_next < last) begin
                gap = ins_gap[ins_next];
                // Random stretch only where the file already leaves a gap
                if (gap > 0) begin
                    gap += {$random(seed)} % 3;
                end
                drive_instr();
            end
        end
        // All retires seen, then a few quiet cycles for the last credits
        drain = 0;
        while (drain < 6) begin
            @(negedge clk);
            in_valid = 1'b0;
            sample_cycle();
            if (ret_next == ret_end) begin
                drain++;
            end
        end
        check_credits(queue_cnt_t'(credits), queue_cnt_t'(ISSUE_DEPTH));
    endtask

    // Unit-1 instructions still in flight when the next reset hits
    task automatic send_stale(input int run);
        int last;
        last = ins_next + run_stale[run];
        while (ins_next < last) begin
            @(negedge clk);
            sample_cycle();
            in_valid = 1'b0;
            if (credits > 0) begin
                drive_instr();
            end
        end
        while (credits != ISSUE_DEPTH) begin
            @(negedge clk);
            in_valid = 1'b0;
            sample_cycle();
        end
        // Let the last issue edge pass
        @(negedge clk);
        in_valid = 1'b0;
        sample_cycle();
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_unit  = '0;
        ins_next = 0;
        ret_next = 0;
        ret_end  = 0;
        load_stimulus();
        for (int r = 0; r < num_runs; r++) begin
            apply_reset();
            run_sequence(r);
            send_stale(r);
        end
        total_errors = retire_errors + credit_errors + init_errors + other_errors
                     + dut0.issue0.asserts0.failures;
        $display("Summary: %0d retire, %0d credit, %0d init, %0d other, %0d assertion errors",
                 retire_errors, credit_errors, init_errors, other_errors,
                 dut0.issue0.asserts0.failures);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
